/* Makefile */
SRCS := $(shell cat ifetch.f)

.PHONY: all run clean

all: run

obj_dir/Vifetch_tb: $(SRCS) ifetch.f
	verilator --binary --timing --top-module ifetch_tb -f ifetch.f -o Vifetch_tb

run: obj_dir/Vifetch_tb
	-./obj_dir/Vifetch_tb > sim.log 2>&1
	cat sim.log
	! grep -q "TB FAILED" sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* common/ifetch_pkg.sv */
package ifetch_pkg;

    // ----------------------------------------
    // cache geometry
    // ----------------------------------------
    localparam int sets_log       = 4;                 // 16 sets
    localparam int sets           = 1 << sets_log;
    localparam int line_words_log = 2;                 // 4 words per line
    localparam int line_words     = 1 << line_words_log;
    localparam int data_words     = sets * line_words; // whole data array

    // address fields
    localparam int offset_bits = line_words_log + 2;   // byte offset in a line
    localparam int tag_bits    = 32 - sets_log - offset_bits;

    // ----------------------------------------
    // memory side
    // ----------------------------------------
    localparam int len_bits = 8;
    localparam logic [len_bits-1:0] refill_len = len_bits'(line_words - 1); // beats - 1

    // fetch start address
    localparam logic [31:0] reset_pc = 32'h0000_0000;

    // ----------------------------------------
    // cache controller states
    // ----------------------------------------
    typedef enum logic [2:0] {
        st_idle,     // waiting for a fetch request
        st_lookup,   // tag compare on the held address
        st_refill,   // line fill from memory in progress
        st_respond,  // response pulse with data
        st_abort     // response pulse with fault set
    } ctrl_state_e;

endpackage

/* common/refill_if.sv */
`timescale 1ns/10ps

// link between cache controller and memory refill port
interface refill_if;

    logic        start;       // one cycle, kicks off a line fill
    logic [31:0] line_addr;   // line aligned
    logic        beat_valid;  // word accepted from memory this cycle
    logic [31:0] beat_data;
    logic        beat_last;   // final word of the line
    logic        fault;       // bus error, refill dropped

    modport ctrl (
        output start,
        output line_addr,
        input  beat_valid,
        input  beat_data,
        input  beat_last,
        input  fault
    );

    modport port (
        input  start,
        input  line_addr,
        output beat_valid,
        output beat_data,
        output beat_last,
        output fault
    );

endinterface

/* icache/icache.sv */
`timescale 1ns/10ps

module icache (
    input  logic        clock,
    input  logic        reset,
    input  logic        fetch_req,
    input  logic [31:0] fetch_addr,
    output logic        fetch_resp,
    output logic [31:0] fetch_data,
    output logic        fetch_fault,
    refill_if.ctrl      refill
);

    // ----------------------------------------
    // address split
    // ----------------------------------------
    logic [ifetch_pkg::tag_bits-1:0]       tag;
    logic [ifetch_pkg::sets_log-1:0]       set_idx;
    logic [ifetch_pkg::line_words_log-1:0] word_idx;

    assign tag      = fetch_addr[31 -: ifetch_pkg::tag_bits];
    assign set_idx  = fetch_addr[ifetch_pkg::offset_bits +: ifetch_pkg::sets_log];
    assign word_idx = fetch_addr[2 +: ifetch_pkg::line_words_log];

    assign refill.line_addr = {fetch_addr[31:ifetch_pkg::offset_bits],
                               {ifetch_pkg::offset_bits{1'b0}}};

    logic                                  hit;
    logic                                  update;
    logic                                  fill_we;
    logic [ifetch_pkg::line_words_log-1:0] fill_word;

    icache_tag_store tag_store_i (
        .clock      (clock),
        .reset      (reset),
        .set_index  (set_idx),
        .tag        (tag),
        .update     (update),
        .invalidate (refill.start),
        .hit        (hit)
    );

    icache_ctrl ctrl_i (
        .clock     (clock),
        .reset     (reset),
        .fetch_req (fetch_req),
        .hit       (hit),
        .update    (update),
        .fill_we   (fill_we),
        .fill_word (fill_word),
        .resp      (fetch_resp),
        .fault     (fetch_fault),
        .refill    (refill)
    );

    // ----------------------------------------
    // data array and response word
    // ----------------------------------------
    logic [31:0] data_mem [ifetch_pkg::data_words];
    logic [31:0] resp_data;

    always_ff @(posedge clock) begin
        if (fill_we) begin
            data_mem[{set_idx, fill_word}] <= refill.beat_data;
        end
    end

    // bypass when the wanted word arrives on the last beat
    always_ff @(posedge clock) begin
        if (fill_we && (fill_word == word_idx)) begin
            resp_data <= refill.beat_data;
        end else begin
            resp_data <= data_mem[{set_idx, word_idx}];
        end
    end

    assign fetch_data = resp_data;

endmodule

/* icache/icache_ctrl.sv */
`timescale 1ns/10ps

module icache_ctrl (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  fetch_req,
    input  logic                                  hit,
    output logic                                  update,
    output logic                                  fill_we,
    output logic [ifetch_pkg::line_words_log-1:0] fill_word,
    output logic                                  resp,
    output logic                                  fault,
    refill_if.ctrl                                refill
);

    ifetch_pkg::ctrl_state_e state;
    ifetch_pkg::ctrl_state_e state_next;

    // ----------------------------------------
    // state machine
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ifetch_pkg::st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ifetch_pkg::st_idle: begin
                if (fetch_req) begin
                    state_next = ifetch_pkg::st_lookup;
                end
            end
            ifetch_pkg::st_lookup: begin
                if (hit) begin
                    state_next = ifetch_pkg::st_respond;
                end else begin
                    state_next = ifetch_pkg::st_refill;
                end
            end
            ifetch_pkg::st_refill: begin
                if (refill.fault) begin
                    state_next = ifetch_pkg::st_abort;    // line stays invalid
                end else if (refill.beat_last) begin
                    state_next = ifetch_pkg::st_respond;
                end
            end
            ifetch_pkg::st_respond: state_next = ifetch_pkg::st_idle;
            ifetch_pkg::st_abort:   state_next = ifetch_pkg::st_idle;
            default:                state_next = ifetch_pkg::st_idle;
        endcase
    end

    // miss found during lookup
    assign refill.start = (state == ifetch_pkg::st_lookup) && !hit;

    // ----------------------------------------
    // beat counting
    // ----------------------------------------
    assign fill_we = (state == ifetch_pkg::st_refill) && refill.beat_valid;
    assign update  = (state == ifetch_pkg::st_refill) && refill.beat_last;

    always_ff @(posedge clock) begin
        if (reset) begin
            fill_word <= '0;
        end else if (refill.start) begin
            fill_word <= '0;
        end else if (fill_we) begin
            fill_word <= fill_word + 1'b1;   // wraps after the last word
        end
    end

    // response pulse straight from state
    assign resp  = (state == ifetch_pkg::st_respond) || (state == ifetch_pkg::st_abort);
    assign fault = (state == ifetch_pkg::st_abort);

endmodule

/* icache/icache_tag_store.sv */
`timescale 1ns/10ps

module icache_tag_store (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [ifetch_pkg::sets_log-1:0]   set_index,
    input  logic [ifetch_pkg::tag_bits-1:0]   tag,
    input  logic                              update,     // refill completed
    input  logic                              invalidate, // refill starting
    output logic                              hit
);

    // ----------------------------------------
    // storage
    // ----------------------------------------
    logic [ifetch_pkg::tag_bits-1:0] tags [ifetch_pkg::sets];
    logic [ifetch_pkg::sets-1:0]     valid;

    // the old line gets overwritten word by word during a fill,
    // so the set stays invalid until the last beat lands
    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else if (update) begin
            valid[set_index] <= 1'b1;
        end else if (invalidate) begin
            valid[set_index] <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (update) begin
            tags[set_index] <= tag;
        end
    end

    assign hit = valid[set_index] && (tags[set_index] == tag);   // current set only

endmodule

/* ifetch.f */
common/ifetch_pkg.sv
common/refill_if.sv
icache/icache_tag_store.sv
icache/icache_ctrl.sv
icache/icache.sv
rtl/mem_refill_port.sv
rtl/fetch_unit.sv
rtl/ifetch_top.sv
verif/ifetch_tb.sv

/* rtl/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit (
    input  logic        clock,
    input  logic        reset,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    output logic        fetch_req,
    output logic [31:0] fetch_addr,
    input  logic        fetch_resp,
    input  logic [31:0] fetch_data,
    input  logic        fetch_fault,
    output logic        instr_valid,
    output logic [31:0] instr,
    output logic [31:0] instr_pc,
    output logic        instr_fault,
    input  logic        instr_ready
);

    logic [31:0] pc;
    logic        redir_pend;  // redirect seen while a fetch was in flight
    logic [31:0] redir_pc;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc          <= ifetch_pkg::reset_pc;
            fetch_req   <= 1'b0;
            instr_valid <= 1'b0;
            redir_pend  <= 1'b0;
        end else if (fetch_req) begin
            if (fetch_resp) begin
                fetch_req <= 1'b0;
                if (redirect || redir_pend) begin
                    // stale response, restart from the new target
                    pc         <= redirect ? redirect_pc : redir_pc;
                    redir_pend <= 1'b0;
                end else begin
                    instr_valid <= 1'b1;
                    instr_fault <= fetch_fault;
                end
            end else if (redirect) begin
                redir_pend <= 1'b1;
            end
        end else if (instr_valid) begin
            if (redirect) begin
                instr_valid <= 1'b0;
                pc          <= redirect_pc;
                fetch_req   <= 1'b1;
            end else if (instr_ready) begin
                instr_valid <= 1'b0;
                fetch_req   <= 1'b1;
                if (!instr_fault) begin
                    pc <= pc + 32'd4;   // faulted pc is fetched again
                end
            end
        end else begin
            fetch_req <= 1'b1;          // idle, start a fetch
            if (redirect) begin
                pc <= redirect_pc;
            end
        end
    end

    // held output word and pending target
    always_ff @(posedge clock) begin
        if (fetch_req && fetch_resp) begin
            instr    <= fetch_data;
            instr_pc <= pc;
        end
        if (redirect) begin
            redir_pc <= redirect_pc;
        end
    end

    assign fetch_addr = pc;

endmodule

/* rtl/ifetch_top.sv */
`timescale 1ns/10ps

module ifetch_top (
    input  logic                            clock,
    input  logic                            reset,
    // decode side
    output logic                            instr_valid,
    output logic [31:0]                     instr,
    output logic [31:0]                     instr_pc,
    output logic                            instr_fault,
    input  logic                            instr_ready,
    input  logic                            redirect,
    input  logic [31:0]                     redirect_pc,
    // memory side
    output logic                            mem_valid,
    input  logic                            mem_ready,
    output logic [31:0]                     mem_addr,
    output logic [ifetch_pkg::len_bits-1:0] mem_len,
    input  logic                            mem_burst,
    input  logic [31:0]                     mem_rdata,
    input  logic                            mem_err
);

    logic        fetch_req;
    logic [31:0] fetch_addr;
    logic        fetch_resp;
    logic [31:0] fetch_data;
    logic        fetch_fault;

    refill_if refill_bus ();

    fetch_unit fetch_i (
        .clock       (clock),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_resp  (fetch_resp),
        .fetch_data  (fetch_data),
        .fetch_fault (fetch_fault),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_fault (instr_fault),
        .instr_ready (instr_ready)
    );

    icache icache_i (
        .clock       (clock),
        .reset       (reset),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_resp  (fetch_resp),
        .fetch_data  (fetch_data),
        .fetch_fault (fetch_fault),
        .refill      (refill_bus.ctrl)
    );

    mem_refill_port refill_port_i (
        .clock     (clock),
        .reset     (reset),
        .refill    (refill_bus.port),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .mem_len   (mem_len),
        .mem_burst (mem_burst),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .mem_err   (mem_err)
    );

endmodule

/* rtl/mem_refill_port.sv */
`timescale 1ns/10ps

module mem_refill_port (
    input  logic                            clock,
    input  logic                            reset,
    refill_if.port                          refill,
    output logic                            mem_valid,
    output logic [31:0]                     mem_addr,
    output logic [ifetch_pkg::len_bits-1:0] mem_len,
    input  logic                            mem_burst,  // level, 1 = one burst
    input  logic                            mem_ready,
    input  logic [31:0]                     mem_rdata,
    input  logic                            mem_err
);

    logic [ifetch_pkg::len_bits-1:0] beat_cnt;
    logic [31:0]                     addr_q;

    // ----------------------------------------
    // beat return to the cache
    // ----------------------------------------
    assign refill.fault      = mem_valid && mem_err;              // error wins over data
    assign refill.beat_valid = mem_valid && mem_ready && !mem_err;
    assign refill.beat_data  = mem_rdata;
    assign refill.beat_last  = refill.beat_valid && (beat_cnt == ifetch_pkg::refill_len);

    always_ff @(posedge clock) begin
        if (reset) begin
            mem_valid <= 1'b0;
            beat_cnt  <= '0;
        end else if (refill.start) begin
            mem_valid <= 1'b1;
            beat_cnt  <= '0;
        end else if (refill.fault) begin
            mem_valid <= 1'b0;
        end else if (refill.beat_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (refill.beat_last) begin
                mem_valid <= 1'b0;
            end
        end
    end

    // single-beat mode walks the line one word at a time
    always_ff @(posedge clock) begin
        if (refill.start) begin
            addr_q <= refill.line_addr;
        end else if (refill.beat_valid && !mem_burst) begin
            addr_q <= addr_q + 32'd4;
        end
    end

    assign mem_addr = addr_q;
    assign mem_len  = ifetch_pkg::refill_len;

endmodule

/* verif/ifetch_tb.sv */
`timescale 1ns/10ps

module ifetch_tb;

    localparam logic [31:0] pattern    = 32'h5a5a_0000;  // memory word = address xor pattern
    localparam int          wait_limit = 2000;           // cycles per wait

    logic        clock;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] instr_pc;
    logic        instr_fault;
    logic        instr_ready;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        mem_valid;
    logic        mem_ready;
    logic [31:0] mem_addr;
    logic [ifetch_pkg::len_bits-1:0] mem_len;
    logic        mem_burst;
    logic [31:0] mem_rdata;
    logic        mem_err;

    integer      seed = 32'haefd_fe54;
    logic        ready_hold;   // decode stalls on purpose
    logic        inject_err;   // next refill gets a bus error
    int          mcnt;         // beats seen by the memory model

    // scoreboard state
    int          cycle;
    int          accept_count;
    int          fault_count;
    int          hits_checked;
    int          single_beats;
    int          burst_beats;
    int          beat_cnt;
    int          req_start;
    logic [31:0] req_q [$];
    logic [31:0] line_addr;
    logic [31:0] exp_pc;
    logic [31:0] prev_instr;
    logic [31:0] prev_pc;
    logic        prev_mv;
    logic        prev_iv;
    logic        prev_req;
    logic        prev_held;
    logic        miss_seen;
    logic        err_seen;

    ifetch_top dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else
            stop_run($sformatf("** Error at %0t: %s expected %h got %h",
                               $time, name, expected, actual));
    endtask

    // ----------------------------------------
    // memory and decode models
    // ----------------------------------------
    always @(posedge clock) begin
        int r;
        if (mem_valid && mem_ready && !mem_err) begin
            mcnt = mcnt + 1;
        end
        #1;
        r = $random(seed);
        if (!mem_valid) begin
            mcnt = 0;
        end
        mem_ready = r[1] | r[2];
        mem_err   = 1'b0;
        if (mem_valid && inject_err) begin
            mem_err    = 1'b1;   // one cycle only
            inject_err = 1'b0;
        end
        mem_rdata   = (mem_burst ? mem_addr + 4 * mcnt : mem_addr) ^ pattern;
        instr_ready = !ready_hold && r[0];
    end

    // ----------------------------------------
    // checks, sampled mid cycle
    // ----------------------------------------
    always @(negedge clock) begin
        if (reset) begin
            prev_mv   = 1'b0;
            prev_iv   = 1'b0;
            prev_req  = 1'b0;
            prev_held = 1'b0;
            miss_seen = 1'b0;
            err_seen  = 1'b0;
            exp_pc    = ifetch_pkg::reset_pc;
        end else begin
            cycle = cycle + 1;
            if (dut_i.fetch_req && !prev_req) begin
                req_start = cycle;
                miss_seen = 1'b0;
            end
            if (mem_valid && !prev_mv) begin   // new refill request
                check_word("mem_addr[3:0]", 32'd0, {28'd0, mem_addr[3:0]});
                check_word("mem_len", 32'(ifetch_pkg::refill_len), 32'(mem_len));
                assert (!instr_valid) else
                    stop_run("a refill request started while the output was held");
                req_q.push_back(mem_addr);
                line_addr = mem_addr;
                beat_cnt  = 0;
                err_seen  = 1'b0;
                miss_seen = 1'b1;
            end
            if (mem_valid && mem_err) begin
                err_seen = 1'b1;
            end
            if (mem_valid && mem_ready && !mem_err) begin
                check_word("mem_addr", mem_burst ? line_addr : line_addr + 4 * beat_cnt,
                           mem_addr);
                beat_cnt = beat_cnt + 1;
                if (mem_burst) burst_beats = burst_beats + 1;
                else single_beats = single_beats + 1;
            end
            if (prev_mv && !mem_valid && !err_seen) begin
                check_word("beat count", ifetch_pkg::line_words, beat_cnt);
            end
            // hit latency, request to instr_valid
            if (instr_valid && !prev_iv && !miss_seen) begin
                check_word("fetch_req to instr_valid cycles", 3, cycle - req_start);
                hits_checked = hits_checked + 1;
            end
            if (prev_held) begin
                assert (instr_valid) else
                    stop_run("instr_valid dropped while instr_ready was low");
                check_word("instr", prev_instr, instr);
                check_word("instr_pc", prev_pc, instr_pc);
            end
            if (redirect) begin
                exp_pc = redirect_pc;   // held or pending output is dropped
            end else if (instr_valid && instr_ready) begin
                check_word("instr_pc", exp_pc, instr_pc);
                // faulted only when this fetch's own refill saw mem_err
                check_word("instr_fault", {31'd0, miss_seen && err_seen}, {31'd0, instr_fault});
                if (instr_fault) begin
                    fault_count = fault_count + 1;   // same pc comes again
                end else begin
                    check_word("instr", instr_pc ^ pattern, instr);
                    exp_pc = exp_pc + 4;
                end
                accept_count = accept_count + 1;
            end
            prev_held  = instr_valid && !instr_ready && !redirect;
            prev_instr = instr;
            prev_pc    = instr_pc;
            prev_mv    = mem_valid;
            prev_iv    = instr_valid;
            prev_req   = dut_i.fetch_req;
        end
    end

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------
    task automatic wait_accepts(input int n);
        int target;
        int t;
        target = accept_count + n;
        t = 0;
        while (accept_count < target) begin
            @(posedge clock);
            t = t + 1;
            if (t > wait_limit) stop_run("timeout while waiting for accepted instructions");
        end
    endtask

    task automatic wait_faults(input int n);
        int t;
        t = 0;
        while (fault_count < n) begin
            @(posedge clock);
            t = t + 1;
            if (t > wait_limit) stop_run("timeout while waiting for a faulted instruction");
        end
    endtask

    // held output and no refill in flight
    task automatic wait_quiet(input logic need_held);
        int t;
        t = 0;
        do begin
            @(posedge clock);
            #1;
            t = t + 1;
            if (t > wait_limit) stop_run("timeout while waiting for the refill port to go idle");
        end while (mem_valid || (need_held && !instr_valid));
    endtask

    task automatic send_redirect(input logic [31:0] pc);
        @(posedge clock);
        #1;
        redirect    = 1'b1;
        redirect_pc = pc;
        @(posedge clock);
        #1;
        redirect = 1'b0;
    endtask

    function automatic int count_requests(input int from, input logic [31:0] addr);
        int n;
        n = 0;
        for (int i = from; i < req_q.size(); i++) begin
            if (req_q[i] == addr) n = n + 1;
        end
        return n;
    endfunction

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        int snap;
        reset       = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        instr_ready = 1'b0;
        mem_ready   = 1'b0;
        mem_rdata   = '0;
        mem_burst   = 1'b0;   // single-beat mode first
        mem_err     = 1'b0;
        ready_hold  = 1'b0;
        inject_err  = 1'b0;
        mcnt        = 0;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;

        wait_accepts(12);   // three lines, in order
        for (int i = 0; i < 3; i++) begin
            check_word("request address", 32'(i * 16), req_q[i]);
        end

        // back into cached lines, no new refills
        send_redirect(32'h0000_0004);
        wait_accepts(1);
        snap = req_q.size();
        wait_accepts(3);
        check_word("request count", snap, req_q.size());

        wait_quiet(1'b0);
        mem_burst = 1'b1;

        // same set, other tag, then back
        snap = req_q.size();
        send_redirect(32'h0000_0100);
        wait_accepts(2);
        check_word("refills of 0x100", 1, count_requests(snap, 32'h0000_0100));
        snap = req_q.size();
        send_redirect(32'h0000_0000);
        wait_accepts(2);
        check_word("refills of 0x0", 1, count_requests(snap, 32'h0000_0000));

        // bus error on a fresh line
        ready_hold = 1'b1;
        wait_quiet(1'b1);
        repeat (8) @(posedge clock);
        snap       = req_q.size();
        inject_err = 1'b1;
        send_redirect(32'h0000_0200);
        ready_hold = 1'b0;
        wait_faults(1);
        wait_accepts(1);
        check_word("refills of 0x200", 2, count_requests(snap, 32'h0000_0200));

        wait_accepts(8);
        if (hits_checked > 0 && single_beats > 0 && burst_beats > 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_run("not every case was reached");
        end
    end

endmodule
